// ==== verilog/spi_defs.svh ====
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

// ############################
// Packet format
// ############################

// Address field width
`define SPI_AW 8
// Data field width
`define SPI_DW 32

// ############################
// Register map
// ############################

// SCLK half-period divider
`define SPI_REG_CFG 8'h00
// Write starts one byte transfer
`define SPI_REG_TX 8'h04

// ############################
// Defaults and pin handling
// ############################

// Divider value out of reset
`define SPI_DIV_RESET 2
// Flops in the slave pin synchronizer
`define SPI_SYNC_STAGES 2

`endif

// ==== verilog/spi_pkg.sv ====
`default_nettype none

`include "spi_defs.svh"

package spi_pkg;

   // ############################
   // Vector types
   // ############################

   typedef logic [`SPI_AW-1:0] spi_addr_t;
   typedef logic [`SPI_DW-1:0] spi_data_t;
   // Serial payload
   typedef logic [7:0] spi_byte_t;
   // SCLK half-period in clk cycles, zero acts as one
   typedef logic [7:0] spi_div_t;

   // ############################
   // Structs
   // ############################

   // emesh-style write/address/data packet
   typedef struct packed {
      logic      write;
      spi_addr_t addr;
      spi_data_t data;
   } emesh_packet_t;

   // Decode to master command
   typedef struct packed {
      logic      start;
      spi_byte_t tx_byte;
      spi_div_t  div;
   } spi_cmd_t;

   // Serial bus lines
   typedef struct packed {
      logic sclk;
      logic mosi;
      logic ss_n;
   } spi_pins_t;

   // Master FSM
   typedef enum logic [1:0] {
      MS_IDLE,
      MS_LOW,
      MS_HIGH,
      MS_GAP
   } master_state_t;

endpackage

`default_nettype wire

// ==== verilog/spi_reg_decode.sv ====
`default_nettype none

`include "spi_defs.svh"

module spi_reg_decode (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic                   access_in,
   input  wire spi_pkg::emesh_packet_t packet_in,
   output logic                        wait_out,
   input  wire logic                   busy,
   output spi_pkg::spi_cmd_t           cmd
);

   // ############################
   // Register state
   // ############################

   spi_pkg::spi_div_t  div_q;
   spi_pkg::spi_byte_t pend_byte;
   logic               pending;
   logic               start_q;

   logic take;
   logic take_cfg;
   logic take_tx;

   // Stall the sender while a byte waits or shifts
   assign wait_out = pending | busy;

   // Packet accepted this edge
   assign take = access_in & ~wait_out;
   // Only writes are decoded, reads fall through and are dropped
   assign take_cfg = take & packet_in.write & (packet_in.addr == `SPI_REG_CFG);
   assign take_tx  = take & packet_in.write & (packet_in.addr == `SPI_REG_TX);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         div_q   <= spi_pkg::spi_div_t'(`SPI_DIV_RESET);
         pending <= 1'b0;
         start_q <= 1'b0;
      end else begin
         // Single-cycle pulse
         start_q <= 1'b0;
         if (take_cfg) begin
            div_q <= spi_pkg::spi_div_t'(packet_in.data[7:0]);
         end
         if (take_tx) begin
            pending <= 1'b1;
         end else if (pending && !busy) begin
            // Hand byte to master
            pending <= 1'b0;
            start_q <= 1'b1;
         end
      end
   end

   // Byte latch
   always_ff @(posedge clk) begin
      if (take_tx) begin
         pend_byte <= packet_in.data[7:0];
      end
   end

   assign cmd.start   = start_q;
   assign cmd.tx_byte = pend_byte;
   assign cmd.div     = div_q;

   // Master picks up each single-cycle start
   a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      start_q |=> busy && !start_q)
      else $error("start not taken up by master");

   // Byte waiting or being handed over keeps the sender stalled
   a_tx_stall: assert property (@(posedge clk) disable iff (!rst_n)
      (pending || start_q) |-> wait_out)
      else $error("wait_out low with byte pending");

endmodule

`default_nettype wire

// ==== verilog/spi_master_shift.sv ====
`default_nettype none

module spi_master_shift (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire spi_pkg::spi_cmd_t cmd,
   output logic                   busy,
   output spi_pkg::spi_pins_t     pins
);

   // ############################
   // State and counters
   // ############################

   spi_pkg::master_state_t state;
   spi_pkg::spi_div_t      half_cnt;
   spi_pkg::spi_div_t      div_lat;
   spi_pkg::spi_div_t      div_eff;
   spi_pkg::spi_byte_t     shreg;
   logic [2:0]             bit_cnt;
   logic                   sclk_q;
   logic                   mosi_q;
   logic                   ss_n_q;

   // Zero divider runs at the fastest rate
   assign div_eff = (cmd.div == '0) ? spi_pkg::spi_div_t'(1) : cmd.div;

   // Busy covers the start cycle too
   assign busy = (state != spi_pkg::MS_IDLE) | cmd.start;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= spi_pkg::MS_IDLE;
         half_cnt <= '0;
         bit_cnt  <= '0;
         sclk_q   <= 1'b0;
         mosi_q   <= 1'b0;
         ss_n_q   <= 1'b1;
      end else begin
         case (state)
            spi_pkg::MS_IDLE: begin
               if (cmd.start) begin
                  // Select slave, first bit on mosi
                  state    <= spi_pkg::MS_LOW;
                  half_cnt <= div_eff - 8'd1;
                  bit_cnt  <= '0;
                  ss_n_q   <= 1'b0;
                  mosi_q   <= cmd.tx_byte[7];
               end
            end
            spi_pkg::MS_LOW: begin
               if (half_cnt != '0) begin
                  half_cnt <= half_cnt - 8'd1;
               end else begin
                  // Rising edge, slave samples here
                  state    <= spi_pkg::MS_HIGH;
                  half_cnt <= div_lat - 8'd1;
                  sclk_q   <= 1'b1;
               end
            end
            spi_pkg::MS_HIGH: begin
               if (half_cnt != '0) begin
                  half_cnt <= half_cnt - 8'd1;
               end else begin
                  sclk_q   <= 1'b0;
                  half_cnt <= div_lat - 8'd1;
                  if (bit_cnt == 3'd7) begin
                     // Last bit done, deselect
                     state  <= spi_pkg::MS_GAP;
                     ss_n_q <= 1'b1;
                  end else begin
                     state   <= spi_pkg::MS_LOW;
                     bit_cnt <= bit_cnt + 3'd1;
                     mosi_q  <= shreg[6];
                  end
               end
            end
            default: begin
               // Idle gap after deselect
               if (half_cnt != '0) begin
                  half_cnt <= half_cnt - 8'd1;
               end else begin
                  state <= spi_pkg::MS_IDLE;
               end
            end
         endcase
      end
   end

   // Shift register and divider copy
   always_ff @(posedge clk) begin
      if (state == spi_pkg::MS_IDLE && cmd.start) begin
         shreg   <= cmd.tx_byte;
         div_lat <= div_eff;
      end else if (state == spi_pkg::MS_HIGH && half_cnt == '0) begin
         // MSB first
         shreg <= {shreg[6:0], 1'b0};
      end
   end

   assign pins.sclk = sclk_q;
   assign pins.mosi = mosi_q;
   assign pins.ss_n = ss_n_q;

   // Slave stays selected across every bit phase
   a_ss_frame: assert property (@(posedge clk) disable iff (!rst_n)
      (state inside {spi_pkg::MS_LOW, spi_pkg::MS_HIGH}) |-> !pins.ss_n)
      else $error("ss_n high during bit phase");

endmodule

`default_nettype wire

// ==== verilog/spi_slave_capture.sv ====
`default_nettype none

`include "spi_defs.svh"

module spi_slave_capture (
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire spi_pkg::spi_pins_t pins,
   input  wire logic               wait_in,
   output logic                    access_out,
   output spi_pkg::emesh_packet_t  packet_out
);

   // ############################
   // Pin synchronizer
   // ############################

   spi_pkg::spi_pins_t sync_q [`SPI_SYNC_STAGES];
   spi_pkg::spi_pins_t pins_s;
   logic               sclk_d;
   logic               ss_n_d;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         // Idle bus levels, no false edges out of reset
         for (int i = 0; i < `SPI_SYNC_STAGES; i++) begin
            sync_q[i] <= '{sclk: 1'b0, mosi: 1'b0, ss_n: 1'b1};
         end
         sclk_d <= 1'b0;
         ss_n_d <= 1'b1;
      end else begin
         sync_q[0] <= pins;
         for (int i = 1; i < `SPI_SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
         sclk_d <= pins_s.sclk;
         ss_n_d <= pins_s.ss_n;
      end
   end

   assign pins_s = sync_q[`SPI_SYNC_STAGES-1];

   // ############################
   // Byte assembly
   // ############################

   logic               sclk_rise;
   logic               ss_rise;
   logic [3:0]         bit_cnt;
   spi_pkg::spi_byte_t rx_q;
   spi_pkg::spi_addr_t pkt_cnt;
   spi_pkg::spi_addr_t next_cnt;
   logic               overrun_q;
   logic               done;
   logic               held;
   logic               frame_ok;

   // Sample point inside a selected frame
   assign sclk_rise = pins_s.sclk & ~sclk_d & ~pins_s.ss_n;
   // End of frame
   assign ss_rise   = pins_s.ss_n & ~ss_n_d;
   // Exactly eight bits seen
   assign frame_ok  = ss_rise & (bit_cnt == 4'd8);

   // Output handshake
   assign done     = access_out & ~wait_in;
   assign held     = access_out & wait_in;
   assign next_cnt = done ? pkt_cnt + 8'd1 : pkt_cnt;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bit_cnt    <= '0;
         pkt_cnt    <= '0;
         overrun_q  <= 1'b0;
         access_out <= 1'b0;
      end else begin
         if (pins_s.ss_n) begin
            bit_cnt <= '0;
         end else if (sclk_rise && bit_cnt != 4'hf) begin
            bit_cnt <= bit_cnt + 4'd1;
         end
         pkt_cnt <= next_cnt;
         if (done) begin
            access_out <= 1'b0;
         end
         if (frame_ok) begin
            if (held) begin
               // Slot still occupied, byte is lost
               overrun_q <= 1'b1;
            end else begin
               access_out <= 1'b1;
               overrun_q  <= 1'b0;
            end
         end
      end
   end

   // Payload registers
   always_ff @(posedge clk) begin
      if (sclk_rise) begin
         rx_q <= {rx_q[6:0], pins_s.mosi};
      end
      if (frame_ok && !held) begin
         packet_out.write <= 1'b1;
         packet_out.addr  <= next_cnt;
         packet_out.data  <= {23'b0, overrun_q, rx_q};
      end
   end

   // Held packet does not change under back-pressure
   a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (access_out && wait_in) |=> (access_out && $stable(packet_out)))
      else $error("packet_out changed while stalled");

endmodule

`default_nettype wire

// ==== verilog/spi_loop_top.sv ====
`default_nettype none

module spi_loop_top (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   // Stimulus side
   input  wire logic                   access_in,
   input  wire spi_pkg::emesh_packet_t packet_in,
   output logic                        wait_out,
   // Result side
   output logic                        access_out,
   output spi_pkg::emesh_packet_t      packet_out,
   input  wire logic                   wait_in
);

   // ############################
   // Internal links
   // ############################

   spi_pkg::spi_cmd_t  cmd;
   spi_pkg::spi_pins_t pins;
   logic               busy;

   // Register writes in, byte commands out
   spi_reg_decode u_decode (
      .clk       (clk),
      .rst_n     (rst_n),
      .access_in (access_in),
      .packet_in (packet_in),
      .wait_out  (wait_out),
      .busy      (busy),
      .cmd       (cmd)
   );

   // Drive through the master
   spi_master_shift u_master (
      .clk   (clk),
      .rst_n (rst_n),
      .cmd   (cmd),
      .busy  (busy),
      .pins  (pins)
   );

   // Observe on the slave
   spi_slave_capture u_slave (
      .clk        (clk),
      .rst_n      (rst_n),
      .pins       (pins),
      .wait_in    (wait_in),
      .access_out (access_out),
      .packet_out (packet_out)
   );

endmodule

`default_nettype wire

// ==== tests/spi_loop_tb.sv ====
`default_nettype none

`include "spi_defs.svh"

module spi_loop_tb;
   timeunit 1ns;
   timeprecision 100ps;

   // ############################
   // DUT and clock
   // ############################

   logic                   clk;
   logic                   rst_n;
   logic                   access_in;
   spi_pkg::emesh_packet_t packet_in;
   logic                   wait_out;
   logic                   access_out;
   spi_pkg::emesh_packet_t packet_out;
   logic                   wait_in;

   spi_loop_top UUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   // 8 ns period
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ############################
   // Stimulus records
   // ############################

   typedef struct packed {
      logic [7:0]  kind;
      logic [31:0] f1;
      logic [31:0] f2;
      logic [31:0] f3;
   } stim_rec_t;

   // One expected result packet
   typedef struct packed {
      logic [7:0] rx_byte;
      logic       ovr;
      logic [7:0] cnt;
   } expect_t;

   stim_rec_t stim_q[$];
   string     name_q[$];
   expect_t   exp_q[$];
   expect_t   mon_exp;

   int          errors = 0;
   int          test_errs = 0;
   int          pass_cnt = 0;
   int          fail_cnt = 0;
   int          cycles = 0;
   int          limit = 200;
   int          hold_len;
   logic        hold_active = 1'b0;
   logic [31:0] rng = 32'h0adb_0af4;
   logic        was_held = 1'b0;
   logic [40:0] held_pkt;

   // Linear congruential step
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual) begin
         $display("Fail t=%0t %s: expected %0h, actual %0h", $time, name, expected, actual);
         errors++;
         test_errs++;
      end
   endtask

   // Whole file up front, timeout budget summed on the way
   task automatic load_stimulus();
      int          fd;
      int          code;
      string       tok;
      string       line;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [7:0]  div;
      div = `SPI_DIV_RESET;
      fd = $fopen("tests/spi_loop_stim.txt", "r");
      if (fd == 0) begin
         $display("Stimulus file tests/spi_loop_stim.txt could not be opened");
         errors++;
         return;
      end
      while (!$feof(fd)) begin
         code = $fscanf(fd, "%s", tok);
         if (code != 1) break;
         a = '0;
         b = '0;
         c = '0;
         if (tok == "#") begin
            code = $fgets(line, fd);
         end else if (tok == "W" || tok == "E") begin
            code = $fscanf(fd, "%h %h %h", a, b, c);
            if (tok == "W" && a[0] && b[7:0] == `SPI_REG_CFG) begin
               div = (c[7:0] == 8'd0) ? 8'd1 : c[7:0];
            end
            if (tok == "W" && a[0] && b[7:0] == `SPI_REG_TX) begin
               limit += 16 * int'(div) + 40;
            end
         end else if (tok == "H") begin
            code = $fscanf(fd, "%d", a);
            limit += int'(a);
         end else if (tok == "T") begin
            code = $fscanf(fd, "%s", line);
            name_q.push_back(line);
         end else begin
            $display("Unknown line type %s in stimulus file", tok);
            errors++;
         end
         if (tok != "#") begin
            stim_q.push_back('{kind: tok.getc(0), f1: a, f2: b, f3: c});
         end
      end
      $fclose(fd);
   endtask

   // ############################
   // Driver
   // ############################

   // Sender holds the packet while wait_out is high
   task automatic send_packet(input logic wr, input logic [7:0] addr, input logic [31:0] data);
      rng = lcg_next(rng);
      repeat (rng[31:30]) @(negedge clk);
      access_in = 1'b1;
      packet_in = '{write: wr, addr: addr, data: data};
      while (wait_out) @(negedge clk);
      // Taken at the next rising edge
      @(negedge clk);
      access_in = 1'b0;
   endtask

   task automatic start_hold(input int n);
      hold_active = 1'b1;
      hold_len = n;
      wait_in = 1'b1;
      fork
         begin
            repeat (hold_len) @(negedge clk);
            wait_in = 1'b0;
            hold_active = 1'b0;
         end
      join_none
   endtask

   // Drain results, then a short quiet window for stray packets
   task automatic finish_test(input string name);
      while (exp_q.size() != 0 || hold_active || wait_out) @(negedge clk);
      repeat (8) @(negedge clk);
      if (test_errs == 0) begin
         pass_cnt++;
         $display("test %s: ok", name);
      end else begin
         fail_cnt++;
         $display("test %s: %0d errors", name, test_errs);
      end
      test_errs = 0;
   endtask

   initial begin
      rst_n = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      wait_in = 1'b0;
      load_stimulus();
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      // Idle levels out of reset
      check_value("access_out", 0, access_out);
      check_value("wait_out", 0, wait_out);
      foreach (stim_q[i]) begin
         case (stim_q[i].kind)
            "W": send_packet(stim_q[i].f1[0], stim_q[i].f2[7:0], stim_q[i].f3);
            "E": exp_q.push_back('{rx_byte: stim_q[i].f1[7:0], ovr: stim_q[i].f2[0],
                                   cnt: stim_q[i].f3[7:0]});
            "H": start_hold(int'(stim_q[i].f1));
            "T": finish_test(name_q.pop_front());
            default: ;
         endcase
      end
      if (exp_q.size() != 0) begin
         $display("%0d expected packets never arrived", exp_q.size());
         errors++;
      end
      $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   // ############################
   // Monitor and timeout
   // ############################

   always @(posedge clk) begin
      if (rst_n) begin
         // Stalled packet must not move
         if (was_held) begin
            check_value("access_out", 1, access_out);
            check_value("packet_out", held_pkt, packet_out);
         end
         was_held = access_out && wait_in;
         held_pkt = packet_out;
         if (access_out && !wait_in) begin
            if (exp_q.size() == 0) begin
               $display("Unexpected packet at t=%0t with addr %0h, no result was pending",
                        $time, packet_out.addr);
               errors++;
               test_errs++;
            end else begin
               mon_exp = exp_q.pop_front();
               check_value("packet_out.write", 1, packet_out.write);
               check_value("packet_out.addr", mon_exp.cnt, packet_out.addr);
               check_value("packet_out.data[7:0]", mon_exp.rx_byte, packet_out.data[7:0]);
               check_value("packet_out.data[8]", mon_exp.ovr, packet_out.data[8]);
               check_value("packet_out.data[31:9]", 0, packet_out.data[31:9]);
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > limit) begin
         $display("Timeout after %0d cycles, the run did not complete", cycles);
         $display("FAIL: see errors above");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== tests/spi_loop_stim.txt ====
# W write_flag addr data | E byte overrun count | H cycles of wait_in high
# T test_name ends a test once its expected packets have arrived
T reset_idle
E a5 0 00
E 3c 0 01
E e1 0 02
W 1 04 000000a5
W 1 04 0000003c
W 1 04 000000e1
T default_divider
W 1 00 00000005
E 5a 0 03
W 1 04 0000005a
W 1 00 00000001
E 81 0 04
W 1 04 00000081
T divider_change
W 1 08 000000ff
W 1 0c 00000012
W 0 04 00000055
W 0 00 00000020
E 99 0 05
W 1 04 00000099
T ignored_packets
E c3 0 06
H 70
W 1 04 000000c3
W 1 04 00000024
T hold_drop
E 66 1 07
W 1 04 00000066
T overrun_flag
E 11 0 08
E 22 0 09
E 33 0 0a
W 1 04 00000011
W 1 04 00000022
W 1 04 00000033
T back_to_back

// ==== flist.f ====
+incdir+verilog
verilog/spi_pkg.sv
verilog/spi_reg_decode.sv
verilog/spi_master_shift.sv
verilog/spi_slave_capture.sv
verilog/spi_loop_top.sv
tests/spi_loop_tb.sv

// ==== Makefile ====
TOP = spi_loop_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --assert -Iverilog verilog/spi_pkg.sv verilog/spi_reg_decode.sv \
		verilog/spi_master_shift.sv verilog/spi_slave_capture.sv verilog/spi_loop_top.sv \
		--top-module spi_loop_top
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "FAIL: see errors above" sim.log; then \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
